//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := lsu_tb
FILELIST := lsu_top.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/lsu_macros.svh
// lsu data width, ram depth and latency defaults, load extension macros
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

`define LSU_XLEN 64

// doublewords
`define LSU_RAM_WORDS 256

// cycles from request transfer to answer, must be at least 1
`define LSU_RAM_LAT 2

// extend the low bits of a named value to LSU_XLEN
`define LSU_SEXT(val, bits) (`LSU_XLEN'($signed(val[(bits)-1:0])))
`define LSU_ZEXT(val, bits) (`LSU_XLEN'(val[(bits)-1:0]))

`endif

//--- lsu_top.f
+incdir+include
src/lsu_pkg.sv
src/bus_pkg.sv
src/chan_buf.sv
src/data_ram.sv
src/lsu_unit.sv
src/lsu_top.sv
sim/lsu_tb.sv

//--- sim/lsu_tb.sv
// lsu testbench: table of stores and loads, shadow memory, lcg stimulus, watchdog
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb
  import lsu_pkg::*;
  import bus_pkg::*;
();

  localparam int RST_CYCLES = 5;
  localparam int MAX_BP     = 3;

  typedef struct packed {
    mem_op_e    op;
    mem_size_e  size;
    addr_t      addr;
    data_t      wdata;
    logic       sext;
    logic [7:0] bp;  // cycles with resp_ready_i low
    logic       err;
    data_t      exp_rdata;
  } entry_t;

  logic      clk, arst_n_i;
  logic      req_valid_i, req_ready_o, req_sext_i;
  mem_op_e   req_op_i;
  mem_size_e req_size_i;
  addr_t     req_addr_i;
  data_t     req_wdata_i;
  logic      resp_valid_o, resp_ready_i, resp_err_o;
  data_t     resp_rdata_o;

  entry_t      tests[$];
  logic [7:0]  shadow [2048];  // byte image of the ram
  logic [31:0] lcg_state = 32'h9ccd17fc;
  int          checks, errors, cycles, limit;

  lsu_top dut (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_size_i   (req_size_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_sext_i   (req_sext_i),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run hung after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bytes from the shadow image, extended per size
  function automatic data_t predict_load(addr_t addr, mem_size_e size, logic sext);
    data_t raw;
    int    base;
    raw  = '0;
    base = int'(addr[10:0]);
    for (int i = 0; i < (1 << size); i++) begin
      raw[8*i +: 8] = shadow[11'(base + i)];
    end
    case (size)
      SZ_B:    return sext ? `LSU_SEXT(raw, 8) : `LSU_ZEXT(raw, 8);
      SZ_H:    return sext ? `LSU_SEXT(raw, 16) : `LSU_ZEXT(raw, 16);
      SZ_W:    return sext ? `LSU_SEXT(raw, 32) : `LSU_ZEXT(raw, 32);
      default: return raw;
    endcase
  endfunction

  task automatic add_entry(mem_op_e op, mem_size_e size, int addr, logic sext,
                           data_t mask = '0);
    entry_t e;
    e.op        = op;
    e.size      = size;
    e.addr      = addr_t'(addr);
    e.wdata     = (op == OP_STORE) ? ({lcg_next(), lcg_next()} | mask) : '0;
    e.sext      = sext;
    e.bp        = 8'((lcg_next() >> 16) % (MAX_BP + 1));
    e.err       = (addr % (1 << size)) != 0;
    e.exp_rdata = '0;
    if (!e.err && op == OP_STORE) begin
      for (int i = 0; i < (1 << size); i++) begin
        shadow[11'(addr + i)] = e.wdata[8*i +: 8];
      end
    end else if (!e.err) begin
      e.exp_rdata = predict_load(e.addr, size, sext);
    end
    tests.push_back(e);
  endtask

  task automatic check_val(string name, data_t got, data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(logic cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("time %0t: %s", $time, what);
    end
  endtask

  task automatic run_entry(int idx);
    entry_t e;
    int     errs_before;
    data_t  held;
    e           = tests[idx];
    errs_before = errors;
    @(negedge clk);
    req_valid_i = 1'b1;
    req_op_i    = e.op;
    req_size_i  = e.size;
    req_addr_i  = e.addr;
    req_wdata_i = e.wdata;
    req_sext_i  = e.sext;
    while (!req_ready_o) @(negedge clk);
    @(negedge clk);  // taken on the edge in between
    req_valid_i = 1'b0;
    while (!resp_valid_o) @(negedge clk);
    check_val("resp_err_o", data_t'(resp_err_o), data_t'(e.err));
    check_val("resp_rdata_o", resp_rdata_o, e.exp_rdata);
    held = resp_rdata_o;
    repeat (e.bp) begin
      @(negedge clk);
      check_true(resp_valid_o, "resp_valid_o dropped while resp_ready_i was low");
      check_val("resp_rdata_o", resp_rdata_o, held);
      check_val("req_ready_o", data_t'(req_ready_o), '0);
    end
    resp_ready_i = 1'b1;
    @(negedge clk);
    resp_ready_i = 1'b0;
    check_true(!resp_valid_o, "resp_valid_o still high after the response transfer");
    $display("test %0d %s size %0d addr %h bp %0d: %s", idx,
             (e.op == OP_STORE) ? "store" : "load", 1 << e.size, e.addr, e.bp,
             (errors == errs_before) ? "ok" : "FAIL");
  endtask

  initial begin
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = OP_LOAD;
    req_size_i   = SZ_B;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_sext_i   = 1'b0;
    resp_ready_i = 1'b0;
    checks       = 0;
    errors       = 0;
    cycles       = 0;
    limit        = 0;

    // store then load at every legal offset, one doubleword per size
    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        add_entry(OP_STORE, mem_size_e'(sz), 'h100 + 8 * sz + off, 1'b0);
        add_entry(OP_LOAD, mem_size_e'(sz), 'h100 + 8 * sz + off, 1'b0);
      end
    end
    // every byte negative
    add_entry(OP_STORE, SZ_D, 'h200, 1'b0, 64'h8080_8080_8080_8080);
    add_entry(OP_LOAD, SZ_B, 'h203, 1'b1);
    add_entry(OP_LOAD, SZ_H, 'h202, 1'b1);
    add_entry(OP_LOAD, SZ_W, 'h204, 1'b1);
    add_entry(OP_LOAD, SZ_B, 'h203, 1'b0);
    // lane merge into a full doubleword
    add_entry(OP_STORE, SZ_D, 'h300, 1'b0);
    add_entry(OP_STORE, SZ_B, 'h303, 1'b0);
    add_entry(OP_STORE, SZ_H, 'h306, 1'b0);
    add_entry(OP_LOAD, SZ_D, 'h300, 1'b0);
    // misaligned, then memory unchanged
    add_entry(OP_STORE, SZ_H, 'h301, 1'b0);
    add_entry(OP_STORE, SZ_W, 'h302, 1'b0);
    add_entry(OP_STORE, SZ_D, 'h304, 1'b0);
    add_entry(OP_LOAD, SZ_W, 'h306, 1'b1);
    add_entry(OP_LOAD, SZ_H, 'h305, 1'b1);
    add_entry(OP_LOAD, SZ_D, 'h300, 1'b0);
    limit = tests.size() * (`LSU_RAM_LAT + 3 + MAX_BP + 4) + RST_CYCLES + 4;

    repeat (RST_CYCLES) begin
      @(negedge clk);
      check_true(!resp_valid_o, "resp_valid_o high during reset");
      check_true(!req_ready_o, "req_ready_o high during reset");
    end
    arst_n_i = 1'b1;
    repeat (2) @(negedge clk);
    check_true(req_ready_o, "req_ready_o did not rise after reset");
    check_true(!resp_valid_o, "resp_valid_o high after reset");
    $display("test reset: %s", (errors == 0) ? "ok" : "FAIL");

    foreach (tests[i]) run_entry(i);

    $display("%0d tests, %0d checks, %0d errors", tests.size() + 1, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- src/bus_pkg.sv
// bus side types: address, data, strobe, write and read request payloads
`include "lsu_macros.svh"

package bus_pkg;

  typedef logic [`LSU_XLEN-1:0]   addr_t;
  typedef logic [`LSU_XLEN-1:0]   data_t;
  typedef logic [`LSU_XLEN/8-1:0] strb_t;  // one bit per byte lane

  // write channel, 136 bits
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wreq_t;

  typedef struct packed {
    addr_t addr;
  } rreq_t;

endpackage

//--- src/chan_buf.sv
// two-entry valid/ready channel buffer with a type-parameterized payload
`timescale 1ns/1ps

module chan_buf #(
  parameter type T = logic [63:0]
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  input  T     in_data_i,
  output logic out_valid_o,
  input  logic out_ready_i,
  output T     out_data_o
);

  T           mem_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] cnt_q;  // 0, 1 or 2 entries
  logic       push, pop;

  assign in_ready_o  = (cnt_q != 2'd2);
  assign out_valid_o = (cnt_q != 2'd0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

//--- src/data_ram.sv
// byte-strobed data ram slave with read and write channels and fixed latency
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_ram
  import bus_pkg::*;
#(
  parameter int DEPTH = `LSU_RAM_WORDS,
  parameter int LAT   = `LSU_RAM_LAT
) (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  wreq_valid_i,
  output logic  wreq_ready_o,
  input  wreq_t wreq_i,
  output logic  wresp_valid_o,
  input  logic  wresp_ready_i,
  input  logic  rreq_valid_i,
  output logic  rreq_ready_o,
  input  rreq_t rreq_i,
  output logic  rdata_valid_o,
  input  logic  rdata_ready_i,
  output data_t rdata_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = (LAT > 1) ? $clog2(LAT) : 1;

  data_t         mem_q [DEPTH];
  data_t         rdata_q;
  logic          busy_q;
  logic          is_wr_q;
  logic [CW-1:0] cnt_q;  // cycles left until the answer
  logic [AW-1:0] widx, ridx;
  logic          take_wr, take_rd, done;

  // doubleword index, wraps at DEPTH
  assign widx = AW'((wreq_i.addr >> 3) % DEPTH);
  assign ridx = AW'((rreq_i.addr >> 3) % DEPTH);

  // write wins when both are valid
  assign wreq_ready_o = !busy_q;
  assign rreq_ready_o = !busy_q && !wreq_valid_i;
  assign take_wr = wreq_valid_i && wreq_ready_o;
  assign take_rd = rreq_valid_i && rreq_ready_o;

  assign wresp_valid_o = busy_q && is_wr_q && (cnt_q == '0);
  assign rdata_valid_o = busy_q && !is_wr_q && (cnt_q == '0);
  assign rdata_o       = rdata_q;

  assign done = (wresp_valid_o && wresp_ready_i) || (rdata_valid_o && rdata_ready_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      is_wr_q <= 1'b0;
      cnt_q   <= '0;
    end else if (take_wr || take_rd) begin
      busy_q  <= 1'b1;
      is_wr_q <= take_wr;
      cnt_q   <= CW'(LAT - 1);
    end else if (busy_q) begin
      if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
      if (done) busy_q <= 1'b0;  // answer held until taken
    end
  end

  always_ff @(posedge clk) begin
    if (take_wr) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (wreq_i.strb[b]) mem_q[widx][8*b +: 8] <= wreq_i.data[8*b +: 8];
      end
    end
    if (take_rd) rdata_q <= mem_q[ridx];
  end

endmodule

//--- src/lsu_pkg.sv
// pipeline side types: memory operation and access size
package lsu_pkg;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // access size in bytes is 1 << size
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } mem_size_e;

endpackage

//--- src/lsu_top.sv
// lsu top: load/store unit, write and read channel buffers, data ram
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  mem_op_e   req_op_i,
  input  mem_size_e req_size_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  input  logic      req_sext_i,
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output data_t     resp_rdata_o,
  output logic      resp_err_o
);

  // lsu side of the buffers
  logic  wreq_valid, wreq_ready, rreq_valid, rreq_ready;
  wreq_t wreq;
  rreq_t rreq;
  // ram side
  logic  ram_wreq_valid, ram_wreq_ready, ram_rreq_valid, ram_rreq_ready;
  wreq_t ram_wreq;
  rreq_t ram_rreq;
  logic  wresp_valid, wresp_ready, rdata_valid, rdata_ready;
  data_t rdata;

  lsu_unit u_lsu (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_size_i    (req_size_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_sext_i    (req_sext_i),
    .wreq_valid_o  (wreq_valid),
    .wreq_ready_i  (wreq_ready),
    .wreq_o        (wreq),
    .wresp_valid_i (wresp_valid),
    .wresp_ready_o (wresp_ready),
    .rreq_valid_o  (rreq_valid),
    .rreq_ready_i  (rreq_ready),
    .rreq_o        (rreq),
    .rdata_valid_i (rdata_valid),
    .rdata_ready_o (rdata_ready),
    .rdata_i       (rdata),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_rdata_o  (resp_rdata_o),
    .resp_err_o    (resp_err_o)
  );

  chan_buf #(.T(wreq_t)) u_wbuf (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (wreq_valid),
    .in_ready_o  (wreq_ready),
    .in_data_i   (wreq),
    .out_valid_o (ram_wreq_valid),
    .out_ready_i (ram_wreq_ready),
    .out_data_o  (ram_wreq)
  );

  chan_buf #(.T(rreq_t)) u_rbuf (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (rreq_valid),
    .in_ready_o  (rreq_ready),
    .in_data_i   (rreq),
    .out_valid_o (ram_rreq_valid),
    .out_ready_i (ram_rreq_ready),
    .out_data_o  (ram_rreq)
  );

  data_ram u_ram (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .wreq_valid_i  (ram_wreq_valid),
    .wreq_ready_o  (ram_wreq_ready),
    .wreq_i        (ram_wreq),
    .wresp_valid_o (wresp_valid),
    .wresp_ready_i (wresp_ready),
    .rreq_valid_i  (ram_rreq_valid),
    .rreq_ready_o  (ram_rreq_ready),
    .rreq_i        (ram_rreq),
    .rdata_valid_o (rdata_valid),
    .rdata_ready_i (rdata_ready),
    .rdata_o       (rdata)
  );

endmodule

//--- src/lsu_unit.sv
// load/store unit: alignment check, lane shifting, channel requests, load extension
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_unit
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  mem_op_e   req_op_i,
  input  mem_size_e req_size_i,
  input  addr_t     req_addr_i,
  input  data_t     req_wdata_i,
  input  logic      req_sext_i,
  output logic      wreq_valid_o,
  input  logic      wreq_ready_i,
  output wreq_t     wreq_o,
  input  logic      wresp_valid_i,
  output logic      wresp_ready_o,
  output logic      rreq_valid_o,
  input  logic      rreq_ready_i,
  output rreq_t     rreq_o,
  input  logic      rdata_valid_i,
  output logic      rdata_ready_o,
  input  data_t     rdata_i,
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output data_t     resp_rdata_o,
  output logic      resp_err_o
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_RESP} state_e;

  state_e    state_q, state_d;
  logic      rdy_q;
  mem_op_e   op_q;
  mem_size_e size_q;
  logic      sext_q;
  logic      err_q;
  addr_t     addr_q;
  data_t     wdata_q;
  data_t     rdata_q;

  logic      accept, misalign, wr_done, rd_done;
  strb_t     strb_base;
  data_t     ld_shift, ld_ext;

  assign accept  = req_valid_i && rdy_q;
  assign wr_done = wresp_valid_i && wresp_ready_o;
  assign rd_done = rdata_valid_i && rdata_ready_o;

  // offset must be a multiple of the size
  always_comb begin
    case (req_size_i)
      SZ_B:    misalign = 1'b0;
      SZ_H:    misalign = req_addr_i[0];
      SZ_W:    misalign = |req_addr_i[1:0];
      default: misalign = |req_addr_i[2:0];
    endcase
  end

  always_comb begin
    case (size_q)
      SZ_B:    strb_base = 8'h01;
      SZ_H:    strb_base = 8'h03;
      SZ_W:    strb_base = 8'h0f;
      default: strb_base = 8'hff;
    endcase
  end

  assign wreq_o.addr = {addr_q[63:3], 3'b000};
  assign wreq_o.data = wdata_q << {addr_q[2:0], 3'b000};
  assign wreq_o.strb = strb_base << addr_q[2:0];
  assign rreq_o.addr = {addr_q[63:3], 3'b000};

  // requested bytes down to lane 0, then extend
  assign ld_shift = rdata_i >> {addr_q[2:0], 3'b000};

  always_comb begin
    case (size_q)
      SZ_B:    ld_ext = sext_q ? `LSU_SEXT(ld_shift, 8) : `LSU_ZEXT(ld_shift, 8);
      SZ_H:    ld_ext = sext_q ? `LSU_SEXT(ld_shift, 16) : `LSU_ZEXT(ld_shift, 16);
      SZ_W:    ld_ext = sext_q ? `LSU_SEXT(ld_shift, 32) : `LSU_ZEXT(ld_shift, 32);
      default: ld_ext = ld_shift;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:  if (accept) state_d = misalign ? S_RESP : S_ISSUE;
      S_ISSUE: begin
        if ((op_q == OP_STORE) ? wreq_ready_i : rreq_ready_i) state_d = S_WAIT;
      end
      S_WAIT:  if (wr_done || rd_done) state_d = S_RESP;
      default: if (resp_ready_i) state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      rdy_q   <= 1'b0;  // rises one cycle after reset
      op_q    <= OP_LOAD;
      size_q  <= SZ_B;
      sext_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      rdy_q   <= (state_d == S_IDLE);
      if (accept) begin
        op_q   <= req_op_i;
        size_q <= req_size_i;
        sext_q <= req_sext_i;
        err_q  <= misalign;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      rdata_q <= '0;  // stores and errors answer zero
    end
    if (rd_done) rdata_q <= ld_ext;
  end

  assign req_ready_o   = rdy_q;
  assign wreq_valid_o  = (state_q == S_ISSUE) && (op_q == OP_STORE);
  assign rreq_valid_o  = (state_q == S_ISSUE) && (op_q == OP_LOAD);
  assign wresp_ready_o = (state_q == S_WAIT) && (op_q == OP_STORE);
  assign rdata_ready_o = (state_q == S_WAIT) && (op_q == OP_LOAD);
  assign resp_valid_o  = (state_q == S_RESP);
  assign resp_rdata_o  = rdata_q;
  assign resp_err_o    = err_q;

endmodule
